// ==== list.f ====
verilog/sdrc_pkg.sv
verilog/sdrc_req_gen.sv
verilog/sdrc_req_fifo.sv
verilog/sdrc_xfr_ctl.sv
verilog/sdrc_core.sv
bench/tb_clock.sv
bench/sdram_model.sv
bench/sdrc_assertions.sv
bench/sdrc_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the SDRAM controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module sdrc_tb -f list.f -o sdrc_sim

status=0
./obj_dir/sdrc_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "RESULT: FAIL" sim.log || ! grep -q "RESULT: PASS" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

// ==== bench/sdrc_tb.sv ====
`timescale 1ns/100ps
// Testbench for the SDR SDRAM controller
// Init order, round trips, burst chopping, back-pressure and random traffic
module sdrc_tb;

  localparam int WATCHDOG_NS = (sdrc_pkg::INIT_WAIT_CYC + 40 * 300) * 4;

  logic clk;
  logic rst_n;
  logic app_req;
  sdrc_pkg::app_addr_t app_req_addr;
  sdrc_pkg::req_len_t  app_req_len;
  logic app_req_wr_n;
  logic app_req_ack;
  sdrc_pkg::sdr_data_t app_wr_data;
  logic app_wr_next_req;
  sdrc_pkg::sdr_data_t app_rd_data;
  logic app_rd_valid;
  logic sdr_init_done;
  logic sdr_cke, sdr_cs_n, sdr_ras_n, sdr_cas_n, sdr_we_n;
  sdrc_pkg::bank_t     sdr_ba;
  sdrc_pkg::row_t      sdr_addr;
  sdrc_pkg::sdr_mask_t sdr_dqm;
  sdrc_pkg::sdr_data_t sdr_dout;
  logic sdr_den_n;
  sdrc_pkg::sdr_data_t pad_sdr_din;

  sdrc_pkg::sdr_data_t shadow [sdrc_pkg::app_addr_t];  // Written words
  sdrc_pkg::app_addr_t wq_addr[$];                     // Write words not yet taken
  sdrc_pkg::sdr_data_t wq_data[$];
  sdrc_pkg::app_addr_t rq_addr[$];                     // Read words still due
  sdrc_pkg::sdr_cmd_t  init_cmds[$];
  sdrc_pkg::row_t      init_addrs[$];
  sdrc_pkg::sdr_cmd_t  cur_cmd;
  sdrc_pkg::app_addr_t rd_addr;
  int data_errs, cmd_errs, count_errs, misc_errs;
  int wr_takes, rd_valids, ack_count, act_count;

  tb_clock #(.PERIOD_NS(4)) u_clock (.clk(clk));

  sdrc_core sdrc_core_inst (.*);

  sdram_model u_sdram (
    .clk(clk), .cs_n(sdr_cs_n), .ras_n(sdr_ras_n), .cas_n(sdr_cas_n), .we_n(sdr_we_n),
    .ba(sdr_ba), .addr(sdr_addr), .dqm(sdr_dqm), .dq_in(sdr_dout), .den_n(sdr_den_n),
    .dq_out(pad_sdr_din)
  );

  // ------------------------------------------------
  // Reference model and compare tasks
  // ------------------------------------------------
  function automatic sdrc_pkg::sdr_data_t expected_word(input sdrc_pkg::app_addr_t a);
    if (shadow.exists(a)) return shadow[a];
    return a[15:0] ^ {10'd0, a[21:16]};     // Power-up pattern of the model
  endfunction

  // Bursts from the chopping rule
  function automatic int num_bursts(input sdrc_pkg::col_t col, input sdrc_pkg::req_len_t len);
    int rem, c, n, take;
    rem = int'(len);
    c   = int'(col);
    n   = 0;
    while (rem > 0) begin
      take = 4 - (c % 4);
      if (take > rem) take = rem;
      rem = rem - take;
      c   = c + take;
      n   = n + 1;
    end
    return n;
  endfunction

  task automatic check_data(input string name, input sdrc_pkg::app_addr_t a,
                            input sdrc_pkg::sdr_data_t got, input sdrc_pkg::sdr_data_t exp);
    if (got !== exp) begin
      $display("FAIL %s addr %h got %h expected %h", name, a, got, exp);
      data_errs++;
    end
  endtask

  task automatic check_cmd(input string name, input sdrc_pkg::sdr_cmd_t got,
                           input sdrc_pkg::sdr_cmd_t exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      cmd_errs++;
    end
  endtask

  task automatic check_addr(input string name, input sdrc_pkg::row_t got,
                            input sdrc_pkg::row_t exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      cmd_errs++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      count_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      misc_errs++;
    end
  endtask

  // ------------------------------------------------
  // Monitors, driven and sampled on the falling edge
  // ------------------------------------------------
  always @(negedge clk) begin
    if (wq_data.size() != 0) app_wr_data = wq_data[0];   // Word on offer
    if (rst_n && app_wr_next_req) begin
      if (wq_data.size() == 0) begin
        $display("controller took a write word that was never supplied");
        misc_errs++;
      end else begin
        shadow[wq_addr[0]] = wq_data[0];
        void'(wq_addr.pop_front());
        void'(wq_data.pop_front());
        wr_takes++;
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n && app_rd_valid) begin
      rd_valids++;
      if (rq_addr.size() == 0) begin
        $display("read word returned with no read outstanding");
        misc_errs++;
      end else begin
        rd_addr = rq_addr.pop_front();
        check_data("app_rd_data", rd_addr, app_rd_data, expected_word(rd_addr));
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n) begin
      cur_cmd = sdrc_pkg::sdr_cmd_t'({sdr_cs_n, sdr_ras_n, sdr_cas_n, sdr_we_n});
      if (cur_cmd != sdrc_pkg::CMD_NOP && !sdr_init_done) begin
        init_cmds.push_back(cur_cmd);
        init_addrs.push_back(sdr_addr);
      end
      if (cur_cmd == sdrc_pkg::CMD_ACTIVE) act_count++;
      if (app_req_ack) ack_count++;
      check_bit("sdr_cke", sdr_cke, 1'b1);              // Clock enable always on
    end
  end

  // ------------------------------------------------
  // Stimulus
  // ------------------------------------------------
  // Hold app_req high afterwards when hold is set, for back-to-back requests
  task automatic issue_req(input sdrc_pkg::app_addr_t a, input sdrc_pkg::req_len_t len,
                           input logic wr_n, input logic hold);
    app_req      = 1'b1;
    app_req_addr = a;
    app_req_len  = len;
    app_req_wr_n = wr_n;
    for (int i = 0; i < int'(len); i++) begin
      if (!wr_n) begin
        wq_addr.push_back(a + sdrc_pkg::app_addr_t'(i));
        wq_data.push_back(sdrc_pkg::sdr_data_t'($urandom));
      end else begin
        rq_addr.push_back(a + sdrc_pkg::app_addr_t'(i));
      end
    end
    do @(negedge clk); while (!app_req_ack);
    if (!hold) app_req = 1'b0;
  endtask

  task automatic wait_drain();
    while (wq_addr.size() != 0 || rq_addr.size() != 0) @(negedge clk);
    repeat (12) @(negedge clk);                 // Let precharge finish
  endtask

  // Outputs while rst_n is low
  task automatic check_reset_state();
    check_cmd("sdr command in reset",
              sdrc_pkg::sdr_cmd_t'({sdr_cs_n, sdr_ras_n, sdr_cas_n, sdr_we_n}),
              sdrc_pkg::CMD_NOP);
    check_bit("sdr_cke", sdr_cke, 1'b1);
    check_bit("app_req_ack", app_req_ack, 1'b0);
    check_bit("app_wr_next_req", app_wr_next_req, 1'b0);
    check_bit("app_rd_valid", app_rd_valid, 1'b0);
    check_bit("sdr_den_n", sdr_den_n, 1'b1);
    check_bit("sdr_init_done", sdr_init_done, 1'b0);
  endtask

  task automatic check_init();
    logic [11:0] ap;
    ap = 12'(1) << sdrc_pkg::AP_BIT;
    check_count("init command count", init_cmds.size(), 4);
    if (init_cmds.size() == 4) begin
      check_cmd("init cmd 0", init_cmds[0], sdrc_pkg::CMD_PRECHARGE);
      check_addr("sdr_addr ap bit", init_addrs[0] & ap, ap);
      check_cmd("init cmd 1", init_cmds[1], sdrc_pkg::CMD_REFRESH);
      check_cmd("init cmd 2", init_cmds[2], sdrc_pkg::CMD_REFRESH);
      check_cmd("init cmd 3", init_cmds[3], sdrc_pkg::CMD_LOAD_MODE);
      check_addr("sdr_addr mode", init_addrs[3], 12'h022);  // BL4, sequential, CL2
    end
  endtask

  initial begin
    int w0, r0, k0, a0, nb;
    sdrc_pkg::app_addr_t a;
    sdrc_pkg::app_addr_t last_wr;
    sdrc_pkg::req_len_t  len;
    logic                wr_n;
    void'($urandom(32'h6cbf_ea7a));
    rst_n = 1'b0;
    app_req = 1'b0;
    app_req_addr = '0;
    app_req_len = 9'd1;
    app_req_wr_n = 1'b1;
    app_wr_data = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    check_reset_state();
    rst_n = 1'b1;
    while (!sdr_init_done) @(negedge clk);
    check_init();

    // Single-word round trip
    w0 = wr_takes;
    r0 = rd_valids;
    issue_req(22'h02_0135, 9'd1, 1'b0, 1'b0);
    issue_req(22'h02_0135, 9'd1, 1'b1, 1'b0);
    wait_drain();
    check_count("app_wr_next_req pulses", wr_takes - w0, 1);
    check_count("app_rd_valid pulses", rd_valids - r0, 1);

    // Ten words from column 6
    a  = {12'h012, 2'd1, 8'd6};
    w0 = wr_takes;
    r0 = rd_valids;
    a0 = act_count;
    issue_req(a, 9'd10, 1'b0, 1'b0);
    issue_req(a, 9'd10, 1'b1, 1'b0);
    wait_drain();
    nb = num_bursts(8'd6, 9'd10);
    check_count("app_wr_next_req pulses", wr_takes - w0, 10);
    check_count("app_rd_valid pulses", rd_valids - r0, 10);
    check_count("ACTIVATE commands", act_count - a0, 2 * nb);

    // Back-to-back requests into a filling queue
    k0 = ack_count;
    for (int j = 0; j < 6; j++) begin
      issue_req(22'h1a_40fa + 22'(j * 16), 9'(4 + 2 * j), 1'b0, 1'b1);
    end
    for (int j = 0; j < 6; j++) begin
      issue_req(22'h1a_40fa + 22'(j * 16), 9'(4 + 2 * j), 1'b1, j != 5);
    end
    wait_drain();
    check_count("app_req_ack pulses", ack_count - k0, 12);

    // Random traffic
    last_wr = '0;
    for (int k = 0; k < 40; k++) begin
      a    = sdrc_pkg::app_addr_t'($urandom);
      wr_n = 1'($urandom % 2);
      len  = sdrc_pkg::req_len_t'($urandom % 32 + 1);
      if ($urandom % 3 == 0) a[7:0] = 8'hf0 | 8'($urandom % 16);  // Cross bank or row
      if (wr_n && ($urandom % 2 == 0)) a = last_wr;               // Read back
      if (!wr_n) last_wr = a;
      issue_req(a, len, wr_n, 1'b0);
    end
    wait_drain();

    $display("errors: data %0d, command %0d, count %0d, other %0d",
             data_errs, cmd_errs, count_errs, misc_errs);
    if (data_errs + cmd_errs + count_errs + misc_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: test sequence did not finish within %0d ns", WATCHDOG_NS);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== bench/sdrc_assertions.sv ====
`timescale 1ns/100ps
// Command bus checks for the SDRAM controller
module sdrc_assertions (
  input logic            clk,
  input logic            rst_n,
  input logic            sdr_cs_n,
  input logic            sdr_ras_n,
  input logic            sdr_cas_n,
  input logic            sdr_we_n,
  input sdrc_pkg::bank_t sdr_ba,
  input logic            sdr_init_done,
  input logic            app_rd_valid
);

  logic [3:0] cmd;
  logic       is_cas;
  logic       is_xfr;

  assign cmd    = {sdr_cs_n, sdr_ras_n, sdr_cas_n, sdr_we_n};
  assign is_cas = (cmd == sdrc_pkg::CMD_READ) || (cmd == sdrc_pkg::CMD_WRITE);
  assign is_xfr = is_cas || (cmd == sdrc_pkg::CMD_ACTIVE);

  // ------------------------------------------------
  // ACTIVATE to CAS spacing
  // ------------------------------------------------
  cas_after_act: assert property (@(posedge clk) disable iff (!rst_n)
    is_cas |-> ($past(cmd, sdrc_pkg::TRCD_CYC) == sdrc_pkg::CMD_ACTIVE) &&
               ($past(sdr_ba, sdrc_pkg::TRCD_CYC) == sdr_ba))
    else $error("READ/WRITE not preceded by ACTIVATE to the same bank");

  // Only init commands until init completes
  no_xfr_in_init: assert property (@(posedge clk) disable iff (!rst_n)
    !sdr_init_done |-> !is_xfr)
    else $error("transfer command issued during init");

  rd_after_init: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(app_rd_valid) |-> sdr_init_done)
    else $error("read data returned before init done");

endmodule

bind sdrc_core sdrc_assertions u_sdrc_assertions (
  .clk           (clk),
  .rst_n         (rst_n),
  .sdr_cs_n      (sdr_cs_n),
  .sdr_ras_n     (sdr_ras_n),
  .sdr_cas_n     (sdr_cas_n),
  .sdr_we_n      (sdr_we_n),
  .sdr_ba        (sdr_ba),
  .sdr_init_done (sdr_init_done),
  .app_rd_valid  (app_rd_valid)
);

// ==== bench/sdram_model.sv ====
`timescale 1ns/100ps
// Behavioral SDR SDRAM for the controller testbench
// Decodes commands, stores masked write bursts, returns read bursts after CAS latency
module sdram_model (
  input  logic                clk,
  input  logic                cs_n,
  input  logic                ras_n,
  input  logic                cas_n,
  input  logic                we_n,
  input  sdrc_pkg::bank_t     ba,
  input  sdrc_pkg::row_t      addr,
  input  sdrc_pkg::sdr_mask_t dqm,
  input  sdrc_pkg::sdr_data_t dq_in,    // Controller drive
  input  logic                den_n,
  output sdrc_pkg::sdr_data_t dq_out    // Toward pad_sdr_din
);

  sdrc_pkg::sdr_data_t mem [0:(1 << 22) - 1];
  sdrc_pkg::row_t      open_row [4];    // Row per bank from ACTIVE
  sdrc_pkg::sdr_cmd_t  cmd;
  sdrc_pkg::bank_t     wr_bank;
  sdrc_pkg::bank_t     rd_bank;
  sdrc_pkg::col_t      wr_col;
  sdrc_pkg::col_t      rd_col;
  int                  wr_left;         // Write beats still to store
  int                  rd_left;         // Read beats still to return
  int                  rd_wait;

  assign cmd = sdrc_pkg::sdr_cmd_t'({cs_n, ras_n, cas_n, we_n});

  function automatic sdrc_pkg::app_addr_t word_addr(input sdrc_pkg::bank_t b,
                                                    input sdrc_pkg::col_t c);
    return {open_row[b], b, c};
  endfunction

  // Sequential burst wraps inside the 4-word block
  function automatic sdrc_pkg::col_t next_col(input sdrc_pkg::col_t c);
    return {c[7:2], c[1:0] + 2'd1};
  endfunction

  task automatic store(input sdrc_pkg::bank_t b, input sdrc_pkg::col_t c);
    if (!den_n && !dqm[0]) mem[word_addr(b, c)][7:0]  = dq_in[7:0];   // Low byte
    if (!den_n && !dqm[1]) mem[word_addr(b, c)][15:8] = dq_in[15:8];  // High byte
  endtask

  // Unwritten words hold an address pattern
  initial begin
    for (int i = 0; i < (1 << 22); i++) begin
      mem[i] = sdrc_pkg::sdr_data_t'(i) ^ {10'd0, 6'(i >> 16)};
    end
    dq_out  = '0;
    wr_left = 0;
    rd_left = 0;
    rd_wait = 0;
  end

  always @(posedge clk) begin
    if (wr_left > 0) begin
      store(wr_bank, wr_col);
      wr_col  = next_col(wr_col);
      wr_left = wr_left - 1;
    end
    if (rd_left > 0) begin
      if (rd_wait > 0) begin
        rd_wait = rd_wait - 1;
      end else begin
        dq_out  <= mem[word_addr(rd_bank, rd_col)];
        rd_col  = next_col(rd_col);
        rd_left = rd_left - 1;
      end
    end
    case (cmd)
      sdrc_pkg::CMD_ACTIVE: open_row[ba] = addr;
      sdrc_pkg::CMD_WRITE: begin
        wr_bank = ba;
        store(ba, addr[7:0]);                     // First beat with the command
        wr_col  = next_col(addr[7:0]);
        wr_left = sdrc_pkg::BURST_LEN - 1;
      end
      sdrc_pkg::CMD_READ: begin
        rd_bank = ba;
        rd_col  = addr[7:0];
        rd_left = sdrc_pkg::BURST_LEN;
        rd_wait = sdrc_pkg::CAS_LAT - 2;          // Command seen one edge late
      end
      default: ;
    endcase
  end

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/100ps
// Testbench clock source
module tb_clock #(
  parameter int PERIOD_NS = 4           // Full clock period
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #(PERIOD_NS / 2) clk = ~clk;   // 50% duty

endmodule

// ==== verilog/sdrc_core.sv ====
`timescale 1ns/100ps
// SDR SDRAM controller top level
// Request generator, burst queue and transfer controller in a chain
module sdrc_core (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 app_req,
  input  sdrc_pkg::app_addr_t  app_req_addr,
  input  sdrc_pkg::req_len_t   app_req_len,
  input  logic                 app_req_wr_n,
  output logic                 app_req_ack,
  input  sdrc_pkg::sdr_data_t  app_wr_data,
  output logic                 app_wr_next_req,
  output sdrc_pkg::sdr_data_t  app_rd_data,
  output logic                 app_rd_valid,
  output logic                 sdr_init_done,
  output logic                 sdr_cke,
  output logic                 sdr_cs_n,
  output logic                 sdr_ras_n,
  output logic                 sdr_cas_n,
  output logic                 sdr_we_n,
  output sdrc_pkg::bank_t      sdr_ba,
  output sdrc_pkg::row_t       sdr_addr,
  output sdrc_pkg::sdr_mask_t  sdr_dqm,
  output sdrc_pkg::sdr_data_t  sdr_dout,
  output logic                 sdr_den_n,
  input  sdrc_pkg::sdr_data_t  pad_sdr_din
);

  // Generator to queue
  logic                 r2f_push;
  logic                 r2f_write;
  sdrc_pkg::bank_t      r2f_bank;
  sdrc_pkg::row_t       r2f_row;
  sdrc_pkg::col_t       r2f_col;
  sdrc_pkg::burst_cnt_t r2f_cnt;
  logic                 f2r_full;

  // Queue to transfer controller
  logic                 f2x_valid;
  logic                 f2x_write;
  sdrc_pkg::bank_t      f2x_bank;
  sdrc_pkg::row_t       f2x_row;
  sdrc_pkg::col_t       f2x_col;
  sdrc_pkg::burst_cnt_t f2x_cnt;
  logic                 x2f_pop;

  // Port and net names match across the stages
  sdrc_req_gen  u_req_gen  (.*);
  sdrc_req_fifo u_req_fifo (.*);
  sdrc_xfr_ctl  u_xfr_ctl  (.*);

endmodule

// ==== verilog/sdrc_xfr_ctl.sv ====
`timescale 1ns/100ps
// Transfer controller for the SDRAM controller
// Runs power-up init, then ACTIVATE and auto-precharge READ/WRITE per burst
module sdrc_xfr_ctl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 f2x_valid,        // Burst waiting in queue
  input  logic                 f2x_write,
  input  sdrc_pkg::bank_t      f2x_bank,
  input  sdrc_pkg::row_t       f2x_row,
  input  sdrc_pkg::col_t       f2x_col,
  input  sdrc_pkg::burst_cnt_t f2x_cnt,
  output logic                 x2f_pop,          // With ACTIVATE
  output logic                 sdr_cke,
  output logic                 sdr_cs_n,
  output logic                 sdr_ras_n,
  output logic                 sdr_cas_n,
  output logic                 sdr_we_n,
  output sdrc_pkg::bank_t      sdr_ba,
  output sdrc_pkg::row_t       sdr_addr,
  output sdrc_pkg::sdr_mask_t  sdr_dqm,
  output sdrc_pkg::sdr_data_t  sdr_dout,
  output logic                 sdr_den_n,        // Drive DQ when low
  input  sdrc_pkg::sdr_data_t  pad_sdr_din,
  input  sdrc_pkg::sdr_data_t  app_wr_data,
  output logic                 app_wr_next_req,  // Word taken this cycle
  output sdrc_pkg::sdr_data_t  app_rd_data,
  output logic                 app_rd_valid,
  output logic                 sdr_init_done
);

  typedef enum logic [2:0] {
    INIT_WAIT,    // Power-up NOPs
    INIT_TRP,     // After precharge all
    INIT_RFC1,    // After first refresh
    INIT_RFC2,    // After second refresh
    INIT_MRD,     // After mode load
    INIT_DONE
  } init_state_t;

  typedef enum logic [1:0] {
    X_IDLE,       // Waiting for a burst
    X_RCD,        // ACTIVATE to CAS spacing
    X_GAP         // Burst, recovery and precharge
  } xfr_state_t;

  init_state_t          init_state;
  xfr_state_t           xfr_state;
  sdrc_pkg::init_cnt_t  init_cnt;
  sdrc_pkg::dly_cnt_t   dly_cnt;
  sdrc_pkg::sdr_cmd_t   cmd_q;           // Command on the pins
  logic                 xfr_write;       // Burst in progress
  sdrc_pkg::col_t       xfr_col;
  sdrc_pkg::burst_cnt_t xfr_cnt;
  logic                 act_go;
  logic                 cas_go;
  logic [sdrc_pkg::BURST_LEN-1:0] wr_beats;   // Write data window
  logic [sdrc_pkg::BURST_LEN-1:0] wr_mask;    // Live words in window
  logic [sdrc_pkg::CAS_LAT+sdrc_pkg::BURST_LEN-1:0] rd_pipe;  // Read tags

  // One bit per beat, set for the first cnt beats
  function automatic logic [sdrc_pkg::BURST_LEN-1:0] beat_mask(
      input sdrc_pkg::burst_cnt_t cnt);
    logic [sdrc_pkg::BURST_LEN-1:0] m;
    for (int i = 0; i < sdrc_pkg::BURST_LEN; i++) begin
      m[i] = (i < int'(cnt));
    end
    return m;
  endfunction

  assign {sdr_cs_n, sdr_ras_n, sdr_cas_n, sdr_we_n} = cmd_q;
  assign sdr_cke = 1'b1;                       // No power-down modes

  assign act_go = sdr_init_done && (xfr_state == X_IDLE) && f2x_valid;
  assign cas_go = (xfr_state == X_RCD) && (dly_cnt == '0);

  // ------------------------------------------------
  // Init and command sequencing
  // ------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      init_state    <= INIT_WAIT;
      init_cnt      <= sdrc_pkg::init_cnt_t'(sdrc_pkg::INIT_WAIT_CYC - 1);
      sdr_init_done <= 1'b0;
      xfr_state     <= X_IDLE;
      dly_cnt       <= '0;
      cmd_q         <= sdrc_pkg::CMD_NOP;
      sdr_ba        <= '0;
      sdr_addr      <= '0;
      x2f_pop       <= 1'b0;
    end else begin
      cmd_q   <= sdrc_pkg::CMD_NOP;            // Default every cycle
      x2f_pop <= act_go;

      if (init_state != INIT_DONE) begin
        if (init_cnt != '0) begin
          init_cnt <= init_cnt - 1'b1;
        end else begin
          case (init_state)
            INIT_WAIT: begin
              cmd_q      <= sdrc_pkg::CMD_PRECHARGE;
              sdr_addr   <= sdrc_pkg::AP_MASK;           // All banks
              init_cnt   <= sdrc_pkg::init_cnt_t'(sdrc_pkg::TRP_CYC - 1);
              init_state <= INIT_TRP;
            end
            INIT_TRP: begin
              cmd_q      <= sdrc_pkg::CMD_REFRESH;
              init_cnt   <= sdrc_pkg::init_cnt_t'(sdrc_pkg::TRFC_CYC - 1);
              init_state <= INIT_RFC1;
            end
            INIT_RFC1: begin
              cmd_q      <= sdrc_pkg::CMD_REFRESH;
              init_cnt   <= sdrc_pkg::init_cnt_t'(sdrc_pkg::TRFC_CYC - 1);
              init_state <= INIT_RFC2;
            end
            INIT_RFC2: begin
              cmd_q      <= sdrc_pkg::CMD_LOAD_MODE;
              sdr_ba     <= '0;
              sdr_addr   <= sdrc_pkg::MODE_REG;
              init_cnt   <= sdrc_pkg::init_cnt_t'(sdrc_pkg::TMRD_CYC - 1);
              init_state <= INIT_MRD;
            end
            default: begin
              sdr_init_done <= 1'b1;                     // Stays high
              init_state    <= INIT_DONE;
            end
          endcase
        end
      end

      case (xfr_state)
        X_IDLE: begin
          if (act_go) begin
            cmd_q     <= sdrc_pkg::CMD_ACTIVE;
            sdr_ba    <= f2x_bank;                       // Held through CAS
            sdr_addr  <= f2x_row;
            dly_cnt   <= sdrc_pkg::dly_cnt_t'(sdrc_pkg::TRCD_CYC - 1);
            xfr_state <= X_RCD;
          end
        end
        X_RCD: begin
          if (!cas_go) begin
            dly_cnt <= dly_cnt - 1'b1;
          end else begin
            cmd_q    <= xfr_write ? sdrc_pkg::CMD_WRITE : sdrc_pkg::CMD_READ;
            sdr_addr <= sdrc_pkg::AP_MASK | sdrc_pkg::row_t'(xfr_col);
            // Next ACTIVATE lands one cycle after X_IDLE is reached
            dly_cnt  <= xfr_write ? sdrc_pkg::dly_cnt_t'(sdrc_pkg::WR_GAP_CYC - 2)
                                  : sdrc_pkg::dly_cnt_t'(sdrc_pkg::RD_GAP_CYC - 2);
            xfr_state <= X_GAP;
          end
        end
        default: begin
          if (dly_cnt != '0) begin
            dly_cnt <= dly_cnt - 1'b1;
          end else begin
            xfr_state <= X_IDLE;
          end
        end
      endcase
    end
  end

  // ------------------------------------------------
  // Data path
  // ------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_beats     <= '0;
      rd_pipe      <= '0;
      app_rd_valid <= 1'b0;
    end else begin
      wr_beats     <= wr_beats >> 1;
      rd_pipe      <= rd_pipe >> 1;
      app_rd_valid <= rd_pipe[0];                // Aligned with registered data
      if (cas_go && xfr_write) begin
        wr_beats <= '1;                          // WRITE cycle and next three
      end
      if (cas_go && !xfr_write) begin
        rd_pipe <= {beat_mask(xfr_cnt), {sdrc_pkg::CAS_LAT{1'b0}}};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (act_go) begin
      xfr_write <= f2x_write;
      xfr_col   <= f2x_col;
      xfr_cnt   <= f2x_cnt;
    end
    wr_mask <= wr_mask >> 1;
    if (cas_go && xfr_write) begin
      wr_mask <= beat_mask(xfr_cnt);
    end
    app_rd_data <= pad_sdr_din;                  // Pad register
  end

  assign app_wr_next_req = wr_beats[0] & wr_mask[0];
  assign sdr_dqm         = {2{wr_beats[0] & ~wr_mask[0]}};  // Mask words past cnt
  assign sdr_den_n       = ~wr_beats[0];
  assign sdr_dout        = app_wr_data;          // App word goes out as taken

endmodule

// ==== verilog/sdrc_req_fifo.sv ====
`timescale 1ns/100ps
// Burst request queue between generator and transfer controller
module sdrc_req_fifo (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 r2f_push,
  input  logic                 r2f_write,
  input  sdrc_pkg::bank_t      r2f_bank,
  input  sdrc_pkg::row_t       r2f_row,
  input  sdrc_pkg::col_t       r2f_col,
  input  sdrc_pkg::burst_cnt_t r2f_cnt,
  output logic                 f2r_full,
  output logic                 f2x_valid,    // Head entry present
  output logic                 f2x_write,
  output sdrc_pkg::bank_t      f2x_bank,
  output sdrc_pkg::row_t       f2x_row,
  output sdrc_pkg::col_t       f2x_col,
  output sdrc_pkg::burst_cnt_t f2x_cnt,
  input  logic                 x2f_pop       // Head consumed
);

  logic                 wr_mem   [sdrc_pkg::FIFO_DEPTH];
  sdrc_pkg::bank_t      bank_mem [sdrc_pkg::FIFO_DEPTH];
  sdrc_pkg::row_t       row_mem  [sdrc_pkg::FIFO_DEPTH];
  sdrc_pkg::col_t       col_mem  [sdrc_pkg::FIFO_DEPTH];
  sdrc_pkg::burst_cnt_t cnt_mem  [sdrc_pkg::FIFO_DEPTH];
  sdrc_pkg::fifo_ptr_t  wr_ptr;
  sdrc_pkg::fifo_ptr_t  rd_ptr;
  sdrc_pkg::fifo_cnt_t  count;       // Occupied slots
  logic                 push;
  logic                 pop;

  assign push      = r2f_push && !f2r_full;
  assign pop       = x2f_pop && f2x_valid;
  assign f2r_full  = (count == sdrc_pkg::fifo_cnt_t'(sdrc_pkg::FIFO_DEPTH));
  assign f2x_valid = (count != '0);

  // Pointers wrap on their own since depth is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;           // Idle or simultaneous
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      wr_mem[wr_ptr]   <= r2f_write;
      bank_mem[wr_ptr] <= r2f_bank;
      row_mem[wr_ptr]  <= r2f_row;
      col_mem[wr_ptr]  <= r2f_col;
      cnt_mem[wr_ptr]  <= r2f_cnt;
    end
  end

  // Head entry straight from storage
  assign f2x_write = wr_mem[rd_ptr];
  assign f2x_bank  = bank_mem[rd_ptr];
  assign f2x_row   = row_mem[rd_ptr];
  assign f2x_col   = col_mem[rd_ptr];
  assign f2x_cnt   = cnt_mem[rd_ptr];

endmodule

// ==== verilog/sdrc_req_gen.sv ====
`timescale 1ns/100ps
// Request generator for the SDRAM controller
// Latches one app request and chops it into 4-word burst requests
module sdrc_req_gen (
  input  logic                 clk,           // Controller clock
  input  logic                 rst_n,         // Async reset
  input  logic                 app_req,       // Held until ack
  input  sdrc_pkg::app_addr_t  app_req_addr,  // Start word address
  input  sdrc_pkg::req_len_t   app_req_len,   // Length in words
  input  logic                 app_req_wr_n,  // 0 write, 1 read
  output logic                 app_req_ack,   // One-cycle accept pulse
  output logic                 r2f_push,      // Burst request valid
  output logic                 r2f_write,
  output sdrc_pkg::bank_t      r2f_bank,
  output sdrc_pkg::row_t       r2f_row,
  output sdrc_pkg::col_t       r2f_col,
  output sdrc_pkg::burst_cnt_t r2f_cnt,
  input  logic                 f2r_full       // Queue cannot take a push
);

  typedef enum logic {
    GEN_IDLE,
    GEN_CHOP
  } gen_state_t;

  gen_state_t           state;
  sdrc_pkg::app_addr_t  cur_addr;    // Next word to issue
  sdrc_pkg::req_len_t   rem_len;     // Words still to issue
  logic                 cur_write;
  sdrc_pkg::burst_cnt_t room;        // Words left in this 4-word block
  sdrc_pkg::burst_cnt_t chunk;       // Size of the next burst
  logic                 last_chunk;
  logic                 take_req;
  logic                 take_slot;

  // ------------------------------------------------
  // Burst sizing
  // ------------------------------------------------
  always_comb begin
    room = sdrc_pkg::burst_cnt_t'(sdrc_pkg::BURST_LEN) - {1'b0, cur_addr[1:0]};
    if (rem_len < sdrc_pkg::req_len_t'(room)) begin
      chunk = sdrc_pkg::burst_cnt_t'(rem_len);   // Short tail
    end else begin
      chunk = room;
    end
    last_chunk = (rem_len == sdrc_pkg::req_len_t'(chunk));
  end

  assign take_req  = (state == GEN_IDLE) && app_req;
  // Output stage is free or drains on this edge
  assign take_slot = (state == GEN_CHOP) && (!r2f_push || !f2r_full);

  // ------------------------------------------------
  // Control
  // ------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= GEN_IDLE;
      app_req_ack <= 1'b0;
      r2f_push    <= 1'b0;
    end else begin
      app_req_ack <= take_req;                  // Pulse, state leaves idle
      if (r2f_push && !f2r_full) begin
        r2f_push <= 1'b0;                       // Accepted by queue
      end
      if (take_req) begin
        state <= GEN_CHOP;
      end else if (take_slot) begin
        r2f_push <= 1'b1;
        if (last_chunk) begin
          state <= GEN_IDLE;
        end
      end
    end
  end

  // Address walk and burst fields
  always_ff @(posedge clk) begin
    if (take_req) begin
      cur_addr  <= app_req_addr;
      rem_len   <= app_req_len;
      cur_write <= ~app_req_wr_n;
    end else if (take_slot) begin
      cur_addr  <= cur_addr + sdrc_pkg::app_addr_t'(chunk);  // Carries into bank, row
      rem_len   <= rem_len - sdrc_pkg::req_len_t'(chunk);
      r2f_write <= cur_write;
      r2f_bank  <= cur_addr[sdrc_pkg::BANK_LSB +: $bits(sdrc_pkg::bank_t)];
      r2f_row   <= cur_addr[sdrc_pkg::ROW_LSB +: $bits(sdrc_pkg::row_t)];
      r2f_col   <= sdrc_pkg::col_t'(cur_addr);
      r2f_cnt   <= chunk;
    end
  end

endmodule

// ==== verilog/sdrc_pkg.sv ====
// SDR SDRAM controller shared definitions
// Device geometry, command encodings and fixed timing for one 16-bit part
package sdrc_pkg;

  // ------------------------------------------------
  // Geometry and data widths
  // ------------------------------------------------
  typedef logic [21:0] app_addr_t;   // Word address {row, bank, col}
  typedef logic [8:0]  req_len_t;    // Request length 1..256 words
  typedef logic [11:0] row_t;        // Row and command address
  typedef logic [7:0]  col_t;        // Column within a row
  typedef logic [1:0]  bank_t;       // Bank select
  typedef logic [15:0] sdr_data_t;   // One device word
  typedef logic [1:0]  sdr_mask_t;   // Byte mask per word
  typedef logic [2:0]  burst_cnt_t;  // Words in one burst 1..4

  localparam int unsigned BANK_LSB = 8;   // Bank field in app_addr_t
  localparam int unsigned ROW_LSB  = 10;  // Row field in app_addr_t

  // ------------------------------------------------
  // Commands as {cs_n, ras_n, cas_n, we_n}
  // ------------------------------------------------
  typedef enum logic [3:0] {
    CMD_LOAD_MODE = 4'b0000,
    CMD_REFRESH   = 4'b0001,
    CMD_PRECHARGE = 4'b0010,
    CMD_ACTIVE    = 4'b0011,
    CMD_WRITE     = 4'b0100,
    CMD_READ      = 4'b0101,
    CMD_NOP       = 4'b0111,
    CMD_DESELECT  = 4'b1111
  } sdr_cmd_t;

  // ------------------------------------------------
  // Timing in clock cycles
  // ------------------------------------------------
  localparam int unsigned BURST_LEN     = 4;
  localparam int unsigned CAS_LAT       = 2;
  localparam int unsigned TRCD_CYC      = 2;    // ACTIVE to READ/WRITE
  localparam int unsigned TRP_CYC       = 2;    // Precharge period
  localparam int unsigned TWR_CYC       = 2;    // Write recovery
  localparam int unsigned TRFC_CYC      = 7;    // Refresh cycle time
  localparam int unsigned TMRD_CYC      = 2;    // Mode load to first use
  localparam int unsigned INIT_WAIT_CYC = 100;  // Shortened power-up wait

  // Every burst auto-precharges, so ACTIVE spacing counts from the CAS command
  localparam int unsigned WR_GAP_CYC = BURST_LEN + TWR_CYC + TRP_CYC;
  localparam int unsigned RD_GAP_CYC = CAS_LAT + BURST_LEN + TRP_CYC;

  localparam int unsigned AP_BIT  = 10;                     // Auto/all precharge
  localparam row_t        AP_MASK = row_t'(1) << AP_BIT;
  localparam row_t        MODE_REG = 12'h022;               // BL4 seq CL2

  localparam int unsigned FIFO_DEPTH = 4;                   // Burst queue slots

  typedef logic [$clog2(FIFO_DEPTH)-1:0]    fifo_ptr_t;
  typedef logic [$clog2(FIFO_DEPTH):0]      fifo_cnt_t;     // 0..FIFO_DEPTH
  typedef logic [$clog2(INIT_WAIT_CYC)-1:0] init_cnt_t;     // Init spacing
  typedef logic [3:0]                       dly_cnt_t;      // Command spacing

endpackage
